//--- synth_macros.svh
////////////////////////////////////////////////////////////////////////////
// size constants for the MIDI voice controller, included by the package
// and by every module that needs a width or a reset value
////////////////////////////////////////////////////////////////////////////
`ifndef SYNTH_MACROS_SVH
`define SYNTH_MACROS_SVH

// number of voices in the pool
`define SYNTH_VOICES 8

// CPU word address width
`define SYNTH_ADDR_W 5

// internal reset stretch, in clock cycles after io_reset drops
`define SYNTH_RST_HOLD 4

// pitch latch reset value, bend wheel at center
`define SYNTH_PITCH_CENTER 14'h2000

`endif

//--- synth_pkg.sv
////////////////////////////////////////////////////////////////////////////
// shared types for the MIDI voice controller
// modules pull these in with a wildcard import in their header
////////////////////////////////////////////////////////////////////////////
`include "synth_macros.svh"

package synth_pkg;

    typedef logic [`SYNTH_VOICES-1:0] voice_mask_t;   // one bit per voice
    typedef logic [6:0]               key_t;          // MIDI key number
    typedef logic [31:0]              reg_word_t;     // CPU data word

    // upper nibble of a status byte
    typedef enum logic [3:0] {
        cmd_note_off = 4'h8,
        cmd_note_on  = 4'h9,
        cmd_poly_at  = 4'hA,
        cmd_ctrl     = 4'hB,
        cmd_prog     = 4'hC,
        cmd_chan_at  = 4'hD,
        cmd_pitch    = 4'hE,
        cmd_system   = 4'hF
    } midi_cmd_e;

    // which data byte the parser expects next
    typedef enum logic [1:0] {
        st_idle,
        st_data1,
        st_data2
    } dec_state_e;

    typedef enum logic [`SYNTH_ADDR_W-1:0] {
        ra_channel = 0,
        ra_keys    = 1,
        ra_status  = 2,
        ra_pitch   = 3,
        ra_voice0  = 8    // voice v at ra_voice0 + v
    } reg_addr_e;

endpackage

//--- reset_delay.sv
////////////////////////////////////////////////////////////////////////////
// stretches io_reset into sys_reset, held SYNTH_RST_HOLD cycles longer
////////////////////////////////////////////////////////////////////////////
`include "synth_macros.svh"

module reset_delay (
    input  logic CLOCK_50,
    input  logic io_reset,
    output logic sys_reset
);

    localparam int CNT_W = $clog2(`SYNTH_RST_HOLD + 1);

    logic [CNT_W-1:0] hold_cnt;

    always_ff @(posedge CLOCK_50) begin
        if (io_reset) begin
            hold_cnt  <= CNT_W'(`SYNTH_RST_HOLD);   // reload while held
            sys_reset <= 1'b1;
        end else begin
            if (hold_cnt != '0) begin
                hold_cnt <= hold_cnt - 1'b1;
            end
            sys_reset <= (hold_cnt != '0);
        end
    end

endmodule

//--- midi_decoder.sv
////////////////////////////////////////////////////////////////////////////
// MIDI byte parser with running status and a channel filter
// emits registered note and pitch-bend pulses for the selected channel
////////////////////////////////////////////////////////////////////////////
`include "synth_macros.svh"

module midi_decoder import synth_pkg::*; (
    input  logic        CLOCK_50,
    input  logic        sys_reset,
    input  logic        midi_write,
    input  logic [7:0]  midi_byte,
    input  logic [3:0]  midi_ch,
    output logic        note_on,
    output logic        note_off,
    output key_t        event_key,
    output logic        pitch_cmd,
    output logic [13:0] pitch_val
);

    dec_state_e state;
    midi_cmd_e  run_cmd;      // running command
    logic [3:0] run_ch;       // running channel
    key_t       data1;        // first data byte of the message

    logic is_rt;
    logic is_common;
    logic is_status;
    logic one_data;
    logic ch_match;

    ////////////////////////////////////////////////////////////////////////////
    // byte classification
    ////////////////////////////////////////////////////////////////////////////

    assign is_rt     = (midi_byte[7:3] == 5'b11111);          // F8..FF
    assign is_common = (midi_byte[7:3] == 5'b11110);          // F0..F7
    assign is_status = midi_byte[7] && (midi_byte[7:4] != 4'hF);

    // program change and channel aftertouch carry a single data byte
    assign one_data = (run_cmd == cmd_prog) || (run_cmd == cmd_chan_at);
    assign ch_match = (run_ch == midi_ch);

    ////////////////////////////////////////////////////////////////////////////
    // parser FSM
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge CLOCK_50) begin
        note_on   <= 1'b0;    // pulses default low
        note_off  <= 1'b0;
        pitch_cmd <= 1'b0;

        if (sys_reset) begin
            state   <= st_idle;
            run_cmd <= cmd_system;
            run_ch  <= 4'h0;
        end else if (midi_write && !is_rt) begin
            if (is_status) begin
                run_cmd <= midi_cmd_e'(midi_byte[7:4]);
                run_ch  <= midi_byte[3:0];
                state   <= st_data1;
            end else if (is_common) begin
                // system common kills running status
                run_cmd <= cmd_system;
                state   <= st_idle;
            end else begin
                case (state)
                    st_data1: begin
                        data1 <= midi_byte[6:0];
                        if (!one_data) begin
                            state <= st_data2;
                        end
                    end
                    st_data2: begin
                        state <= st_data1;    // ready for the next pair
                        if (ch_match) begin
                            case (run_cmd)
                                cmd_note_on: begin
                                    // zero velocity means release
                                    note_on   <= (midi_byte[6:0] != 7'd0);
                                    note_off  <= (midi_byte[6:0] == 7'd0);
                                    event_key <= data1;
                                end
                                cmd_note_off: begin
                                    note_off  <= 1'b1;
                                    event_key <= data1;
                                end
                                cmd_pitch: begin
                                    pitch_cmd <= 1'b1;
                                    pitch_val <= {midi_byte[6:0], data1};   // msb byte second
                                end
                                default: ;
                            endcase
                        end
                    end
                    default: ;    // stray data in idle is dropped
                endcase
            end
        end
    end

endmodule

//--- voice_allocator.sv
////////////////////////////////////////////////////////////////////////////
// voice table, note-on takes the lowest free voice, note-off frees by key
// keys stay stored after release so the CPU can still read them
////////////////////////////////////////////////////////////////////////////
`include "synth_macros.svh"

module voice_allocator import synth_pkg::*; (
    input  logic                       CLOCK_50,
    input  logic                       sys_reset,
    input  logic                       note_on,
    input  logic                       note_off,
    input  key_t                       event_key,
    input  logic                       clear_drop,
    output voice_mask_t                keys_on,
    output key_t [`SYNTH_VOICES-1:0]   voice_keys,
    output logic                       drop_sticky
);

    localparam int VIDX_W = $clog2(`SYNTH_VOICES);

    voice_mask_t       key_match;     // held voices playing event_key
    logic              any_free;
    logic [VIDX_W-1:0] free_idx;

    always_comb begin
        for (int v = 0; v < `SYNTH_VOICES; v++) begin
            key_match[v] = keys_on[v] && (voice_keys[v] == event_key);
        end
    end

    // priority search, walking down so the lowest index wins
    always_comb begin
        any_free = 1'b0;
        free_idx = '0;
        for (int v = `SYNTH_VOICES - 1; v >= 0; v--) begin
            if (!keys_on[v]) begin
                any_free = 1'b1;
                free_idx = VIDX_W'(v);
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // table update
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge CLOCK_50) begin
        if (sys_reset) begin
            keys_on     <= '0;
            voice_keys  <= '0;
            drop_sticky <= 1'b0;
        end else begin
            if (clear_drop) begin
                drop_sticky <= 1'b0;
            end

            if (note_off) begin
                keys_on <= keys_on & ~key_match;   // release every match
            end else if (note_on && (key_match == '0)) begin
                if (any_free) begin
                    keys_on[free_idx]    <= 1'b1;
                    voice_keys[free_idx] <= event_key;
                end else begin
                    drop_sticky <= 1'b1;   // pool full, note lost
                end
            end
            // note_on on a held key is a retrigger, table unchanged
        end
    end

endmodule

//--- synth_regs.sv
////////////////////////////////////////////////////////////////////////////
// CPU register bank: channel select, pitch latch and voice readback
////////////////////////////////////////////////////////////////////////////
`include "synth_macros.svh"

module synth_regs import synth_pkg::*; (
    input  logic                       CLOCK_50,
    input  logic                       sys_reset,
    input  logic                       chipselect,
    input  logic                       cpu_read,
    input  logic                       cpu_write,
    input  logic [`SYNTH_ADDR_W-1:0]   address,
    input  reg_word_t                  writedata,
    input  logic                       pitch_cmd,
    input  logic [13:0]                pitch_val,
    input  voice_mask_t                keys_on,
    input  key_t [`SYNTH_VOICES-1:0]   voice_keys,
    input  logic                       drop_sticky,
    output reg_word_t                  readdata,
    output logic [3:0]                 midi_ch,
    output logic                       clear_drop
);

    localparam int CNT_W  = $clog2(`SYNTH_VOICES + 1);
    localparam int VIDX_W = $clog2(`SYNTH_VOICES);

    logic                     rd_en;
    logic                     wr_en;
    logic [13:0]              pitch_lat;
    logic [CNT_W-1:0]         active_cnt;
    logic [`SYNTH_ADDR_W-1:0] voice_off;
    reg_word_t                rd_mux;

    assign rd_en      = chipselect && cpu_read;
    assign wr_en      = chipselect && cpu_write;
    assign clear_drop = rd_en && (address == ra_status);   // read clears sticky
    assign voice_off  = address - ra_voice0;

    always_comb begin
        active_cnt = '0;
        for (int v = 0; v < `SYNTH_VOICES; v++) begin
            active_cnt = active_cnt + CNT_W'(keys_on[v]);
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // read mux, unmapped words return zero
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        rd_mux = '0;
        case (address)
            ra_channel: rd_mux[3:0] = midi_ch;
            ra_keys:    rd_mux[`SYNTH_VOICES-1:0] = keys_on;
            ra_status: begin
                rd_mux[CNT_W-1:0] = active_cnt;
                rd_mux[8]         = drop_sticky;
            end
            ra_pitch:   rd_mux[13:0] = pitch_lat;
            default: begin
                if ((address >= ra_voice0) && (voice_off < `SYNTH_VOICES)) begin
                    rd_mux[6:0] = voice_keys[voice_off[VIDX_W-1:0]];
                end
            end
        endcase
    end

    always_ff @(posedge CLOCK_50) begin
        if (sys_reset) begin
            midi_ch   <= 4'h0;
            pitch_lat <= `SYNTH_PITCH_CENTER;
            readdata  <= '0;
        end else begin
            if (wr_en && (address == ra_channel)) begin
                midi_ch <= writedata[3:0];   // only channel register is writable
            end
            if (pitch_cmd) begin
                pitch_lat <= pitch_val;
            end
            if (rd_en) begin
                readdata <= rd_mux;          // held until next read
            end
        end
    end

endmodule

//--- synthesizer.sv
////////////////////////////////////////////////////////////////////////////
// top level of the MIDI voice controller, wires the four blocks together
////////////////////////////////////////////////////////////////////////////
`include "synth_macros.svh"

module synthesizer import synth_pkg::*; (
    input  logic                       CLOCK_50,
    input  logic                       io_reset,
    input  logic                       midi_write,
    input  logic [7:0]                 midi_byte,
    input  logic                       chipselect,
    input  logic                       cpu_read,
    input  logic                       cpu_write,
    input  logic [`SYNTH_ADDR_W-1:0]   address,
    input  reg_word_t                  writedata,
    output reg_word_t                  readdata,
    output voice_mask_t                keys_on
);

    logic                     sys_reset;
    logic                     note_on;
    logic                     note_off;
    key_t                     event_key;
    logic                     pitch_cmd;
    logic [13:0]              pitch_val;
    logic [3:0]               midi_ch;
    key_t [`SYNTH_VOICES-1:0] voice_keys;
    logic                     drop_sticky;
    logic                     clear_drop;

    reset_delay u_reset_delay (
        .CLOCK_50  (CLOCK_50),
        .io_reset  (io_reset),
        .sys_reset (sys_reset)
    );

    midi_decoder u_midi_decoder (
        .CLOCK_50  (CLOCK_50),
        .sys_reset (sys_reset),
        .midi_write(midi_write),
        .midi_byte (midi_byte),
        .midi_ch   (midi_ch),
        .note_on   (note_on),
        .note_off  (note_off),
        .event_key (event_key),
        .pitch_cmd (pitch_cmd),
        .pitch_val (pitch_val)
    );

    voice_allocator u_voice_allocator (
        .CLOCK_50    (CLOCK_50),
        .sys_reset   (sys_reset),
        .note_on     (note_on),
        .note_off    (note_off),
        .event_key   (event_key),
        .clear_drop  (clear_drop),
        .keys_on     (keys_on),
        .voice_keys  (voice_keys),
        .drop_sticky (drop_sticky)
    );

    synth_regs u_synth_regs (
        .CLOCK_50    (CLOCK_50),
        .sys_reset   (sys_reset),
        .chipselect  (chipselect),
        .cpu_read    (cpu_read),
        .cpu_write   (cpu_write),
        .address     (address),
        .writedata   (writedata),
        .pitch_cmd   (pitch_cmd),
        .pitch_val   (pitch_val),
        .keys_on     (keys_on),
        .voice_keys  (voice_keys),
        .drop_sticky (drop_sticky),
        .readdata    (readdata),
        .midi_ch     (midi_ch),
        .clear_drop  (clear_drop)
    );

endmodule

//--- synthesizer_chk.sv
////////////////////////////////////////////////////////////////////////////
// assertions on the decoder pulses and the internal reset, bound into
// every synthesizer instance
////////////////////////////////////////////////////////////////////////////
module synthesizer_chk import synth_pkg::*; (
    input logic        CLOCK_50,
    input logic        sys_reset,
    input logic        note_on,
    input logic        note_off,
    input logic        pitch_cmd,
    input voice_mask_t keys_on
);

    timeunit 1ns;
    timeprecision 100ps;

    // one event per completed message
    a_note_excl: assert property (@(posedge CLOCK_50) disable iff (sys_reset !== 1'b0)
        !(note_on && note_off))
        else $error("note_on and note_off are high in the same cycle");

    // table stays empty through the whole reset stretch
    a_reset_keys: assert property (@(posedge CLOCK_50)
        (sys_reset && $past(sys_reset)) |-> (keys_on == '0))
        else $error("keys_on is not zero during sys_reset");

    a_pitch_alone: assert property (@(posedge CLOCK_50) disable iff (sys_reset !== 1'b0)
        !(pitch_cmd && (note_on || note_off)))
        else $error("pitch_cmd coincides with a note pulse");

endmodule

bind synthesizer synthesizer_chk u_chk (.*);

//--- tb_synthesizer.sv
////////////////////////////////////////////////////////////////////////////
// testbench for the MIDI voice controller, drives MIDI bytes and CPU
// accesses and compares against a byte-level reference model
////////////////////////////////////////////////////////////////////////////
`include "synth_macros.svh"

module tb_synthesizer import synth_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_TESTS       = 6;
    localparam int CYCLES_PER_TEST = 2000;

    logic                     CLOCK_50;
    logic                     io_reset;
    logic                     midi_write;
    logic [7:0]               midi_byte;
    logic                     chipselect;
    logic                     cpu_read;
    logic                     cpu_write;
    logic [`SYNTH_ADDR_W-1:0] address;
    reg_word_t                writedata;
    reg_word_t                readdata;
    voice_mask_t              keys_on;

    ////////////////////////////////////////////////////////////////////////////
    // reference model state
    ////////////////////////////////////////////////////////////////////////////
    dec_state_e  m_state;
    midi_cmd_e   m_cmd;
    logic [3:0]  m_ch;          // running channel
    logic [3:0]  m_midi_ch;     // selected channel
    key_t        m_data1;
    voice_mask_t m_keys;
    key_t        m_vkeys [`SYNTH_VOICES];
    logic        m_drop;
    logic [13:0] m_pitch;

    int         err_count;
    int         check_count;
    int         errs_at_start;
    logic [3:0] sel_ch;

    synthesizer dut (.*);

    initial begin
        CLOCK_50 = 1'b0;
        forever #5 CLOCK_50 = ~CLOCK_50;
    end

    // watchdog
    initial begin
        #(NUM_TESTS * CYCLES_PER_TEST * 10);
        $display("run timed out after %0d cycles", NUM_TESTS * CYCLES_PER_TEST);
        $display("test failed");
        $finish;
    end

    function automatic void alloc_voice(input key_t k);
        for (int v = 0; v < `SYNTH_VOICES; v++) begin
            if (m_keys[v] && (m_vkeys[v] == k)) begin
                return;    // retrigger
            end
        end
        for (int v = 0; v < `SYNTH_VOICES; v++) begin
            if (!m_keys[v]) begin
                m_keys[v]  = 1'b1;
                m_vkeys[v] = k;
                return;
            end
        end
        m_drop = 1'b1;
    endfunction

    function automatic void release_key(input key_t k);
        for (int v = 0; v < `SYNTH_VOICES; v++) begin
            if (m_vkeys[v] == k) begin
                m_keys[v] = 1'b0;
            end
        end
    endfunction

    function automatic void model_byte(input logic [7:0] b);
        if (b >= 8'hF8) begin
            return;              // realtime, no effect
        end
        if (b >= 8'hF0) begin
            m_cmd   = cmd_system;
            m_state = st_idle;
            return;
        end
        if (b[7]) begin
            m_cmd   = midi_cmd_e'(b[7:4]);
            m_ch    = b[3:0];
            m_state = st_data1;
            return;
        end
        case (m_state)
            st_data1: begin
                m_data1 = b[6:0];
                if ((m_cmd != cmd_prog) && (m_cmd != cmd_chan_at)) begin
                    m_state = st_data2;
                end
            end
            st_data2: begin
                m_state = st_data1;
                if (m_ch == m_midi_ch) begin
                    if ((m_cmd == cmd_note_on) && (b[6:0] != 7'd0)) begin
                        alloc_voice(m_data1);
                    end else if ((m_cmd == cmd_note_on) || (m_cmd == cmd_note_off)) begin
                        release_key(m_data1);
                    end else if (m_cmd == cmd_pitch) begin
                        m_pitch = (14'(b[6:0]) << 7) + 14'(m_data1);
                    end
                end
            end
            default: ;
        endcase
    endfunction

    function automatic reg_word_t expected_reg(input logic [`SYNTH_ADDR_W-1:0] a);
        reg_word_t r;
        r = '0;
        if (a == ra_channel) begin
            r[3:0] = m_midi_ch;
        end else if (a == ra_keys) begin
            r[`SYNTH_VOICES-1:0] = m_keys;
        end else if (a == ra_status) begin
            r[3:0] = 4'($countones(m_keys));
            r[8]   = m_drop;
        end else if (a == ra_pitch) begin
            r[13:0] = m_pitch;
        end else if ((a >= ra_voice0) && (a < ra_voice0 + `SYNTH_VOICES)) begin
            r[6:0] = m_vkeys[a - ra_voice0];
        end
        return r;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // bus tasks, inputs change 1 ns after the edge
    ////////////////////////////////////////////////////////////////////////////
    task automatic send_byte(input logic [7:0] b);
        @(posedge CLOCK_50);
        #1;
        midi_write = 1'b1;
        midi_byte  = b;
        @(posedge CLOCK_50);
        #1;
        midi_write = 1'b0;
        model_byte(b);
    endtask

    // table has taken the event one edge after the note pulse
    task automatic wait_event();
        @(posedge CLOCK_50);
        #1;
    endtask

    task automatic send_message(input logic [7:0] st, input logic [7:0] d1,
                                input logic [7:0] d2);
        send_byte(st);
        send_byte(d1);
        send_byte(d2);
        wait_event();
    endtask

    task automatic cpu_write_reg(input logic [`SYNTH_ADDR_W-1:0] a, input reg_word_t d);
        @(posedge CLOCK_50);
        #1;
        chipselect = 1'b1;
        cpu_write  = 1'b1;
        address    = a;
        writedata  = d;
        @(posedge CLOCK_50);
        #1;
        chipselect = 1'b0;
        cpu_write  = 1'b0;
        if (a == ra_channel) begin
            m_midi_ch = d[3:0];
        end
    endtask

    task automatic cpu_read_reg(input logic [`SYNTH_ADDR_W-1:0] a, output reg_word_t d);
        @(posedge CLOCK_50);
        #1;
        chipselect = 1'b1;
        cpu_read   = 1'b1;
        address    = a;
        @(posedge CLOCK_50);
        #1;
        chipselect = 1'b0;
        cpu_read   = 1'b0;
        d = readdata;
        if (a == ra_status) begin
            m_drop = 1'b0;     // status read clears the sticky flag
        end
    endtask

    task automatic check_keys(input string name, input voice_mask_t exp, input voice_mask_t got);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("FAILED %s expected %h actual %h", name, exp, got);
        end
    endtask

    task automatic check_reg(input string name, input reg_word_t exp, input reg_word_t got);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("FAILED %s expected %h actual %h", name, exp, got);
        end
    endtask

    task automatic read_and_check(input logic [`SYNTH_ADDR_W-1:0] a, input string name);
        reg_word_t exp;
        reg_word_t got;
        exp = expected_reg(a);
        cpu_read_reg(a, got);
        check_reg(name, exp, got);
    endtask

    task automatic end_test(input string name);
        $display("%s finished, %0d errors", name, err_count - errs_at_start);
        errs_at_start = err_count;
    endtask

    initial begin
        key_t       k;
        logic [7:0] vel;
        logic [7:0] msb;
        logic [3:0] other_ch;
        reg_word_t  rd;
        reg_word_t  exp;

        io_reset   = 1'b1;
        midi_write = 1'b0;
        midi_byte  = 8'h00;
        chipselect = 1'b0;
        cpu_read   = 1'b0;
        cpu_write  = 1'b0;
        address    = '0;
        writedata  = '0;
        void'($urandom(31));

        m_state   = st_idle;
        m_cmd     = cmd_system;
        m_ch      = 4'h0;
        m_midi_ch = 4'h0;
        m_data1   = '0;
        m_keys    = '0;
        m_drop    = 1'b0;
        m_pitch   = `SYNTH_PITCH_CENTER;
        for (int v = 0; v < `SYNTH_VOICES; v++) begin
            m_vkeys[v] = '0;
        end
        err_count     = 0;
        check_count   = 0;
        errs_at_start = 0;

        repeat (5) @(posedge CLOCK_50);
        #1;
        io_reset = 1'b0;
        repeat (`SYNTH_RST_HOLD + 2) @(posedge CLOCK_50);
        #1;

        // 1: reset values and channel register
        check_reg("readdata", '0, readdata);
        check_keys("keys_on", m_keys, keys_on);
        read_and_check(ra_channel, "channel");
        read_and_check(ra_keys, "keys");
        read_and_check(ra_status, "status");
        read_and_check(ra_pitch, "pitch");
        for (int v = 0; v < `SYNTH_VOICES; v++) begin
            read_and_check(`SYNTH_ADDR_W'(ra_voice0 + v), "voice_key");
        end
        repeat (4) begin
            cpu_write_reg(ra_channel, $urandom());
            read_and_check(ra_channel, "channel");
        end
        cpu_write_reg(ra_pitch, $urandom());    // read-only, ignored
        read_and_check(ra_pitch, "pitch");
        sel_ch = 4'($urandom_range(0, 15));
        cpu_write_reg(ra_channel, reg_word_t'(sel_ch));
        end_test("channel register");

        // 2: allocation and retrigger
        repeat (5) begin
            k   = 7'($urandom_range(0, 127));
            vel = 8'($urandom_range(1, 127));
            send_message({4'h9, sel_ch}, {1'b0, k}, vel);
            check_keys("keys_on", m_keys, keys_on);
        end
        for (int v = 0; v < `SYNTH_VOICES; v++) begin
            read_and_check(`SYNTH_ADDR_W'(ra_voice0 + v), "voice_key");
        end
        exp = reg_word_t'(m_keys);
        send_message({4'h9, sel_ch}, {1'b0, m_vkeys[0]}, 8'h50);
        check_keys("keys_on", m_keys, keys_on);
        check_keys("keys_on", exp[`SYNTH_VOICES-1:0], keys_on);
        end_test("allocation");

        // 3: note-off, then zero velocity under running status
        send_message({4'h8, sel_ch}, {1'b0, m_vkeys[0]}, 8'h40);
        check_keys("keys_on", m_keys, keys_on);
        send_byte({4'h9, sel_ch});
        for (int v = 1; v < `SYNTH_VOICES; v++) begin
            if (m_keys[v]) begin
                send_byte({1'b0, m_vkeys[v]});
                send_byte(8'h00);
                wait_event();
                check_keys("keys_on", m_keys, keys_on);
            end
        end
        read_and_check(ra_status, "status");
        read_and_check(ra_keys, "keys");
        end_test("release");

        // 4: other channel, realtime, stray data, program change
        other_ch = sel_ch + 4'd1;
        send_message({4'h9, other_ch}, 8'h40, 8'h60);
        check_keys("keys_on", m_keys, keys_on);
        send_byte({4'h9, sel_ch});
        send_byte(8'hF8);
        send_byte(8'h41);
        send_byte(8'hF8);
        send_byte(8'h7F);
        wait_event();
        check_keys("keys_on", m_keys, keys_on);
        send_byte(8'hF0);    // drops the note-on running status
        send_byte(8'h44);
        send_byte(8'h45);
        send_byte(8'hF7);
        send_byte(8'h46);
        wait_event();
        check_keys("keys_on", m_keys, keys_on);
        send_byte({4'hC, sel_ch});
        send_byte(8'h05);
        send_byte(8'h42);
        send_byte(8'h43);
        wait_event();
        check_keys("keys_on", m_keys, keys_on);
        read_and_check(ra_status, "status");
        end_test("filtering");

        // 5: more notes than voices
        send_byte({4'h9, sel_ch});
        for (int i = 0; i < `SYNTH_VOICES + 2; i++) begin
            send_byte(8'h20 + 8'(i));
            send_byte(8'h30);
            wait_event();
        end
        check_keys("keys_on", '1, keys_on);
        check_keys("keys_on", m_keys, keys_on);
        exp = expected_reg(ra_status);
        cpu_read_reg(ra_status, rd);
        check_reg("status", exp, rd);
        check_reg("drop_sticky", 32'h1, reg_word_t'(rd[8]));
        exp = expected_reg(ra_status);
        cpu_read_reg(ra_status, rd);
        check_reg("status", exp, rd);
        check_reg("drop_sticky", 32'h0, reg_word_t'(rd[8]));
        end_test("overflow");

        // 6: pitch bend, lsb first
        repeat (4) begin
            vel = 8'($urandom_range(0, 127));
            msb = 8'($urandom_range(0, 127));
            send_message({4'hE, sel_ch}, vel, msb);
            read_and_check(ra_pitch, "pitch");
        end
        end_test("pitch bend");

        $display("%0d checks, %0d errors", check_count, err_count);
        if (err_count == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

//--- filelist.f
+incdir+.
synth_pkg.sv
reset_delay.sv
midi_decoder.sv
voice_allocator.sv
synth_regs.sv
synthesizer.sv
synthesizer_chk.sv
tb_synthesizer.sv

//--- Bender.yml
package:
  name: synthesizer

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - synth_pkg.sv
      - reset_delay.sv
      - midi_decoder.sv
      - voice_allocator.sv
      - synth_regs.sv
      - synthesizer.sv
  - target: test
    include_dirs:
      - .
    files:
      - synthesizer_chk.sv
      - tb_synthesizer.sv
